// ==== source/mduPkg.sv ====
package mduPkg;

	//////////////////////////////
	// Widths
	//////////////////////////////
	localparam int dataWidth = 32;
	localparam int regAddrWidth = 5;

	//////////////////////////////
	// Instruction encodings
	//////////////////////////////
	// Opcode field of all R-type words
	localparam logic [5:0] opSpecial = 6'h00;

	localparam logic [5:0] functMfhi = 6'h10;
	localparam logic [5:0] functMthi = 6'h11;
	localparam logic [5:0] functMflo = 6'h12;
	localparam logic [5:0] functMtlo = 6'h13;
	localparam logic [5:0] functMult = 6'h18;
	localparam logic [5:0] functMultu = 6'h19;
	localparam logic [5:0] functDiv = 6'h1a;
	localparam logic [5:0] functDivu = 6'h1b;
	// Custom op, bigger divided by smaller
	localparam logic [5:0] functBds = 6'h1f;

	// Edges from issue to HI/LO update
	localparam int multLatency = 5;
	localparam int divLatency = 10;
	localparam int cntWidth = $clog2(divLatency + 1);

	typedef enum logic [3:0] {
		opNone,
		opMult,
		opMultu,
		opDiv,
		opDivu,
		opBds,
		opMthi,
		opMtlo,
		opMfhi,
		opMflo
	} mduOp_t;

	// Ops that occupy the unit for several cycles
	function automatic logic isArithOp(mduOp_t op);
		return op inside {opMult, opMultu, opDiv, opDivu, opBds};
	endfunction

endpackage

// ==== source/instrDecode.sv ====
`timescale 1ns/1ps

module instrDecode (
	input  logic                            clk,
	input  logic                            reset,
	input  logic [mduPkg::dataWidth-1:0]    instr,
	input  logic                            instrValid,
	input  logic                            busy,
	output mduPkg::mduOp_t                  op,
	output logic [mduPkg::regAddrWidth-1:0] rs,
	output logic [mduPkg::regAddrWidth-1:0] rt,
	output logic [mduPkg::regAddrWidth-1:0] rd,
	output logic                            stall
);
	import mduPkg::*;

	mduOp_t decodedOp;
	logic mduClass;
	logic accept;

	// Field decode of the incoming word
	always_comb begin
		decodedOp = opNone;
		if (instr[31:26] == opSpecial) begin
			case (instr[5:0])
				functMult: decodedOp = opMult;
				functMultu: decodedOp = opMultu;
				functDiv: decodedOp = opDiv;
				functDivu: decodedOp = opDivu;
				functBds: decodedOp = opBds;
				functMthi: decodedOp = opMthi;
				functMtlo: decodedOp = opMtlo;
				functMfhi: decodedOp = opMfhi;
				functMflo: decodedOp = opMflo;
				default: decodedOp = opNone;
			endcase
		end
	end

	assign mduClass = (decodedOp != opNone);

	// Hold the source while the unit is taken or about to be
	assign stall = instrValid && mduClass && (busy || isArithOp(op));
	assign accept = instrValid && !stall;

	//////////////////////////////
	// Stage 2 register
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			op <= opNone;
		end else if (accept) begin
			op <= decodedOp;
		end else begin
			// Bubble
			op <= opNone;
		end
	end

	// Register indices only move with an accepted word
	always_ff @(posedge clk) begin
		if (accept) begin
			rs <= instr[25:21];
			rt <= instr[20:16];
			rd <= instr[15:11];
		end
	end

endmodule

// ==== source/regFile.sv ====
`timescale 1ns/1ps

module regFile (
	input  logic                            clk,
	input  logic                            reset,
	input  logic [mduPkg::regAddrWidth-1:0] rs,
	input  logic [mduPkg::regAddrWidth-1:0] rt,
	input  logic                            wbEn,
	input  logic [mduPkg::regAddrWidth-1:0] wbAddr,
	input  logic [mduPkg::dataWidth-1:0]    wbData,
	input  logic                            loadEn,
	input  logic [mduPkg::regAddrWidth-1:0] loadAddr,
	input  logic [mduPkg::dataWidth-1:0]    loadData,
	output logic [mduPkg::dataWidth-1:0]    srcA,
	output logic [mduPkg::dataWidth-1:0]    srcB
);
	import mduPkg::*;

	localparam int numRegs = 2 ** regAddrWidth;

	// Register zero has no storage
	logic [dataWidth-1:0] regs [1:numRegs-1];

	logic wbHit;
	logic loadHit;

	assign wbHit = wbEn && (wbAddr != '0);
	assign loadHit = loadEn && (loadAddr != '0);

	// Writeback wins over preload
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 1; i < numRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (wbHit) begin
			regs[wbAddr] <= wbData;
		end else if (loadHit) begin
			regs[loadAddr] <= loadData;
		end
	end

	// Read with writeback bypass
	function automatic logic [dataWidth-1:0] readPort(logic [regAddrWidth-1:0] addr);
		if (addr == '0) begin
			return '0;
		end else if (wbHit && (wbAddr == addr)) begin
			return wbData;
		end
		return regs[addr];
	endfunction

	always_comb begin
		srcA = readPort(rs);
		srcB = readPort(rt);
	end

endmodule

// ==== source/mulDivUnit.sv ====
`timescale 1ns/1ps

module mulDivUnit (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         flush,
	input  mduPkg::mduOp_t               op,
	input  logic [mduPkg::dataWidth-1:0] srcA,
	input  logic [mduPkg::dataWidth-1:0] srcB,
	output logic [mduPkg::dataWidth-1:0] hi,
	output logic [mduPkg::dataWidth-1:0] lo,
	output logic [mduPkg::dataWidth-1:0] mduOut,
	output logic                         busy
);
	import mduPkg::*;

	logic [dataWidth-1:0] hiTmp;
	logic [dataWidth-1:0] loTmp;
	logic [cntWidth-1:0] count;

	logic issue;
	logic lastCycle;

	// Full width products
	logic signed [2*dataWidth-1:0] sProd;
	logic [2*dataWidth-1:0] uProd;

	// Quotients and remainders
	logic [dataWidth-1:0] sQuot;
	logic [dataWidth-1:0] sRem;
	logic [dataWidth-1:0] uQuot;
	logic [dataWidth-1:0] uRem;

	// bds operands, larger value is the dividend
	logic [dataWidth-1:0] bigger;
	logic [dataWidth-1:0] smaller;

	assign issue = isArithOp(op) && !busy;
	assign lastCycle = (count == cntWidth'(1));

	//////////////////////////////
	// Arithmetic
	//////////////////////////////
	assign sProd = $signed(srcA) * $signed(srcB);
	assign uProd = srcA * srcB;

	// Signed results truncate toward zero, remainder takes dividend sign
	assign sQuot = $signed(srcA) / $signed(srcB);
	assign sRem = $signed(srcA) % $signed(srcB);
	assign uQuot = srcA / srcB;
	assign uRem = srcA % srcB;

	assign bigger = (srcA >= srcB) ? srcA : srcB;
	assign smaller = (srcA >= srcB) ? srcB : srcA;

	// Results wait here until the countdown ends
	always_ff @(posedge clk) begin
		if (issue) begin
			case (op)
				opMult: begin
					hiTmp <= sProd[2*dataWidth-1:dataWidth];
					loTmp <= sProd[dataWidth-1:0];
				end
				opMultu: begin
					hiTmp <= uProd[2*dataWidth-1:dataWidth];
					loTmp <= uProd[dataWidth-1:0];
				end
				opDiv: begin
					hiTmp <= sRem;
					loTmp <= sQuot;
				end
				opDivu: begin
					hiTmp <= uRem;
					loTmp <= uQuot;
				end
				default: begin
					hiTmp <= bigger % smaller;
					loTmp <= bigger / smaller;
				end
			endcase
		end
	end

	//////////////////////////////
	// HI/LO and countdown
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (reset || flush) begin
			hi <= '0;
			lo <= '0;
			busy <= 1'b0;
			count <= '0;
		end else if (busy) begin
			if (lastCycle) begin
				hi <= hiTmp;
				lo <= loTmp;
				busy <= 1'b0;
				count <= '0;
			end else begin
				count <= count - 1'b1;
			end
		end else if (issue) begin
			busy <= 1'b1;
			if (op == opMult || op == opMultu) begin
				count <= cntWidth'(multLatency);
			end else begin
				count <= cntWidth'(divLatency);
			end
		end else if (op == opMthi) begin
			hi <= srcA;
		end else if (op == opMtlo) begin
			lo <= srcA;
		end
	end

	// Move-from result for writeback
	always_comb begin
		case (op)
			opMfhi: mduOut = hi;
			opMflo: mduOut = lo;
			default: mduOut = '0;
		endcase
	end

endmodule

// ==== source/resultWriteback.sv ====
`timescale 1ns/1ps

module resultWriteback (
	input  logic                            clk,
	input  logic                            reset,
	input  mduPkg::mduOp_t                  op,
	input  logic [mduPkg::regAddrWidth-1:0] rd,
	input  logic [mduPkg::dataWidth-1:0]    mduOut,
	output logic                            wbEn,
	output logic [mduPkg::regAddrWidth-1:0] wbAddr,
	output logic [mduPkg::dataWidth-1:0]    wbData
);
	import mduPkg::*;

	logic isMoveFrom;
	logic writeReq;

	assign isMoveFrom = (op == opMfhi) || (op == opMflo);

	// Writes to register zero are dropped here
	assign writeReq = isMoveFrom && (rd != '0);

	// Write strobe
	always_ff @(posedge clk) begin
		if (reset) begin
			wbEn <= 1'b0;
		end else begin
			wbEn <= writeReq;
		end
	end

	// Destination and value, only meaningful with wbEn
	always_ff @(posedge clk) begin
		if (writeReq) begin
			wbAddr <= rd;
			wbData <= mduOut;
		end
	end

endmodule

// ==== source/mduTop.sv ====
`timescale 1ns/1ps

module mduTop (
	input  logic                            clk,
	input  logic                            reset,
	input  logic [mduPkg::dataWidth-1:0]    instr,
	input  logic                            instrValid,
	input  logic                            flush,
	input  logic                            loadEn,
	input  logic [mduPkg::regAddrWidth-1:0] loadAddr,
	input  logic [mduPkg::dataWidth-1:0]    loadData,
	output logic                            stall,
	output logic                            busy,
	output logic [mduPkg::dataWidth-1:0]    hi,
	output logic [mduPkg::dataWidth-1:0]    lo,
	output logic                            wbEn,
	output logic [mduPkg::regAddrWidth-1:0] wbAddr,
	output logic [mduPkg::dataWidth-1:0]    wbData
);
	import mduPkg::*;

	// Stage 2 content
	mduOp_t op;
	logic [regAddrWidth-1:0] rs;
	logic [regAddrWidth-1:0] rt;
	logic [regAddrWidth-1:0] rd;

	// Operands and move-from result
	logic [dataWidth-1:0] srcA;
	logic [dataWidth-1:0] srcB;
	logic [dataWidth-1:0] mduOut;

	instrDecode decode0 (
		.clk(clk),
		.reset(reset),
		.instr(instr),
		.instrValid(instrValid),
		.busy(busy),
		.op(op),
		.rs(rs),
		.rt(rt),
		.rd(rd),
		.stall(stall)
	);

	regFile regFile0 (
		.clk(clk),
		.reset(reset),
		.rs(rs),
		.rt(rt),
		.wbEn(wbEn),
		.wbAddr(wbAddr),
		.wbData(wbData),
		.loadEn(loadEn),
		.loadAddr(loadAddr),
		.loadData(loadData),
		.srcA(srcA),
		.srcB(srcB)
	);

	mulDivUnit mdu0 (
		.clk(clk),
		.reset(reset),
		.flush(flush),
		.op(op),
		.srcA(srcA),
		.srcB(srcB),
		.hi(hi),
		.lo(lo),
		.mduOut(mduOut),
		.busy(busy)
	);

	resultWriteback writeback0 (
		.clk(clk),
		.reset(reset),
		.op(op),
		.rd(rd),
		.mduOut(mduOut),
		.wbEn(wbEn),
		.wbAddr(wbAddr),
		.wbData(wbData)
	);

endmodule

// ==== testbench/mduChecker.sv ====
`timescale 1ns/1ps

module mduChecker (
	input  logic                            clk,
	input  logic                            reset,
	input  logic [mduPkg::dataWidth-1:0]    instr,
	input  logic                            instrValid,
	input  logic                            flush,
	input  logic                            loadEn,
	input  logic [mduPkg::regAddrWidth-1:0] loadAddr,
	input  logic [mduPkg::dataWidth-1:0]    loadData,
	input  logic                            stall,
	input  logic                            busy,
	input  logic [mduPkg::dataWidth-1:0]    hi,
	input  logic [mduPkg::dataWidth-1:0]    lo,
	input  logic                            wbEn,
	input  logic [mduPkg::regAddrWidth-1:0] wbAddr,
	input  logic [mduPkg::dataWidth-1:0]    wbData,
	output int                              errorCount,
	output int                              checkCount
);
	import mduPkg::*;

	// Reference state after the last edge
	logic [dataWidth-1:0] modelRegs [0:31];
	logic [dataWidth-1:0] expHi;
	logic [dataWidth-1:0] expLo;
	logic [dataWidth-1:0] pendHi;
	logic [dataWidth-1:0] pendLo;
	logic [dataWidth-1:0] expWbData;
	logic [regAddrWidth-1:0] expWbAddr;
	logic [regAddrWidth-1:0] s2Rs;
	logic [regAddrWidth-1:0] s2Rt;
	logic [regAddrWidth-1:0] s2Rd;
	logic expBusy;
	logic expStall;
	logic expWbEn;
	logic primed = 1'b0;
	mduOp_t s2Op;
	int countLeft;

	function automatic mduOp_t decodeWord(logic [dataWidth-1:0] word);
		if (word[31:26] != opSpecial) begin
			return opNone;
		end
		case (word[5:0])
			functMult: return opMult;
			functMultu: return opMultu;
			functDiv: return opDiv;
			functDivu: return opDivu;
			functBds: return opBds;
			functMthi: return opMthi;
			functMtlo: return opMtlo;
			functMfhi: return opMfhi;
			functMflo: return opMflo;
			default: return opNone;
		endcase
	endfunction

	function automatic logic takesUnit(mduOp_t op);
		return op == opMult || op == opMultu || op == opDiv || op == opDivu || op == opBds;
	endfunction

	//////////////////////////////
	// Reference HI/LO
	//////////////////////////////
	function automatic logic [63:0] refHiLo(mduOp_t op, logic [31:0] a, logic [31:0] b);
		logic signed [63:0] sProd;
		logic [31:0] magA;
		logic [31:0] magB;
		logic [31:0] q;
		logic [31:0] r;
		magA = a[31] ? -a : a;
		magB = b[31] ? -b : b;
		case (op)
			opMult: begin
				sProd = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
				return sProd;
			end
			opMultu: return {32'd0, a} * {32'd0, b};
			opDiv: begin
				// Divide magnitudes and give the remainder the dividend sign
				q = magA / magB;
				r = magA % magB;
				if (a[31] ^ b[31]) begin
					q = -q;
				end
				if (a[31]) begin
					r = -r;
				end
				return {r, q};
			end
			opDivu: return {a % b, a / b};
			default: begin
				if (a >= b) begin
					return {a % b, a / b};
				end
				return {b % a, b / a};
			end
		endcase
	endfunction

	// Register read with same-cycle writeback visible
	function automatic logic [dataWidth-1:0] readReg(logic [regAddrWidth-1:0] addr);
		if (addr == '0) begin
			return '0;
		end
		if (expWbEn && expWbAddr == addr) begin
			return expWbData;
		end
		return modelRegs[addr];
	endfunction

	task automatic compare(string name, logic [31:0] got, logic [31:0] exp);
		checkCount++;
		if (got !== exp) begin
			errorCount++;
			$display("ERR %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	// Advance the model across the coming edge
	task automatic stepModel();
		logic [dataWidth-1:0] a;
		logic [dataWidth-1:0] b;
		logic accepted;
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				modelRegs[i] = '0;
			end
			expHi = '0;
			expLo = '0;
			expBusy = 1'b0;
			expWbEn = 1'b0;
			countLeft = 0;
			s2Op = opNone;
		end else begin
			a = readReg(s2Rs);
			b = readReg(s2Rt);
			accepted = instrValid && !expStall;
			if (expWbEn) begin
				modelRegs[expWbAddr] = expWbData;
			end else if (loadEn && loadAddr != '0) begin
				modelRegs[loadAddr] = loadData;
			end
			// mfhi/mflo see HI/LO as they are before this edge
			expWbEn = (s2Op == opMfhi || s2Op == opMflo) && s2Rd != '0;
			expWbAddr = s2Rd;
			expWbData = (s2Op == opMfhi) ? expHi : expLo;
			if (flush) begin
				expHi = '0;
				expLo = '0;
				expBusy = 1'b0;
				countLeft = 0;
			end else if (expBusy) begin
				countLeft--;
				if (countLeft == 0) begin
					expHi = pendHi;
					expLo = pendLo;
					expBusy = 1'b0;
				end
			end else if (takesUnit(s2Op)) begin
				{pendHi, pendLo} = refHiLo(s2Op, a, b);
				expBusy = 1'b1;
				countLeft = (s2Op == opMult || s2Op == opMultu) ? multLatency : divLatency;
			end else if (s2Op == opMthi) begin
				expHi = a;
			end else if (s2Op == opMtlo) begin
				expLo = a;
			end
			s2Op = accepted ? decodeWord(instr) : opNone;
			if (accepted) begin
				s2Rs = instr[25:21];
				s2Rt = instr[20:16];
				s2Rd = instr[15:11];
			end
		end
	endtask

	//////////////////////////////
	// Compare at the falling edge
	//////////////////////////////
	always @(negedge clk) begin
		expStall = instrValid && (decodeWord(instr) != opNone) && (expBusy || takesUnit(s2Op));
		if (primed) begin
			compare("busy", 32'(busy), 32'(expBusy));
			compare("stall", 32'(stall), 32'(expStall));
			compare("hi", hi, expHi);
			compare("lo", lo, expLo);
			compare("wbEn", 32'(wbEn), 32'(expWbEn));
			if (expWbEn) begin
				compare("wbAddr", 32'(wbAddr), 32'(expWbAddr));
				compare("wbData", wbData, expWbData);
			end
		end
		// Comparing starts once the model has seen reset
		if (reset) begin
			primed = 1'b1;
		end
		stepModel();
	end

endmodule

// ==== testbench/tbTop.sv ====
`timescale 1ns/1ps

module tbTop;
	import mduPkg::*;

	// Cycles any single wait may take
	localparam int waitLimit = 40;

	logic clk;
	logic reset;
	logic [dataWidth-1:0] instr;
	logic instrValid;
	logic flush;
	logic loadEn;
	logic [regAddrWidth-1:0] loadAddr;
	logic [dataWidth-1:0] loadData;
	logic stall;
	logic busy;
	logic [dataWidth-1:0] hi;
	logic [dataWidth-1:0] lo;
	logic wbEn;
	logic [regAddrWidth-1:0] wbAddr;
	logic [dataWidth-1:0] wbData;
	int errorCount;
	int checkCount;
	int seed;

	mduTop dut0 (.*);

	mduChecker checker0 (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [31:0] buildWord(logic [5:0] funct, logic [4:0] rs,
			logic [4:0] rt, logic [4:0] rd);
		return {opSpecial, rs, rt, rd, 5'd0, funct};
	endfunction

	function automatic int randBelow(int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	// Registers 1 to 9 hold divisors and are never written back
	function automatic logic [4:0] divisorReg();
		return 5'(1 + randBelow(9));
	endfunction

	task automatic abortRun(string what);
		$display("Timeout while waiting for %s", what);
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		$display("Simulation failed");
		$finish;
	endtask

	//////////////////////////////
	// Stimulus tasks
	//////////////////////////////
	task automatic preloadRegs();
		logic [31:0] value;
		for (int r = 1; r < 32; r++) begin
			value = $random(seed);
			if (r < 10 && (value == '0 || value == '1)) begin
				value = 32'h0001_2345;
			end
			loadEn <= 1'b1;
			loadAddr <= 5'(r);
			loadData <= value;
			@(posedge clk);
		end
		loadEn <= 1'b0;
	endtask

	// Present a word and hold it until an edge takes it
	task automatic issueWord(logic [31:0] word);
		int cycles;
		instr <= word;
		instrValid <= 1'b1;
		cycles = 0;
		@(negedge clk);
		while (stall) begin
			cycles++;
			if (cycles > waitLimit) begin
				abortRun("stall to fall");
			end
			@(negedge clk);
		end
		@(posedge clk);
		instrValid <= 1'b0;
	endtask

	task automatic waitBusy(logic level);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (busy !== level) begin
			cycles++;
			if (cycles > waitLimit) begin
				abortRun("busy to change");
			end
			@(negedge clk);
		end
		@(posedge clk);
	endtask

	// Arithmetic op, then moves back to back, with dependent reads
	task automatic moveSequence(logic [5:0] arithFunct);
		issueWord(buildWord(arithFunct, 5'd1, 5'd2, 5'd0));
		issueWord(buildWord(functMfhi, 5'd0, 5'd0, 5'd11));
		issueWord(buildWord(functMflo, 5'd0, 5'd0, 5'd12));
		issueWord(buildWord(functMfhi, 5'd0, 5'd0, 5'd0));
		issueWord(buildWord(functMflo, 5'd0, 5'd0, 5'd13));
		// r13 arrives through the bypass
		issueWord(buildWord(functMtlo, 5'd13, 5'd0, 5'd0));
		issueWord(buildWord(functMthi, 5'd11, 5'd0, 5'd0));
		issueWord(buildWord(functMultu, 5'd11, 5'd12, 5'd0));
		issueWord(buildWord(functMfhi, 5'd0, 5'd0, 5'd14));
	endtask

	task automatic issueRandom();
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		rs = 5'(randBelow(32));
		rt = 5'(randBelow(32));
		rd = (randBelow(8) == 0) ? 5'd0 : 5'(10 + randBelow(22));
		case (randBelow(9))
			0: issueWord(buildWord(functMult, rs, rt, 5'd0));
			1: issueWord(buildWord(functMultu, rs, rt, 5'd0));
			2: issueWord(buildWord(functDiv, rs, divisorReg(), 5'd0));
			3: issueWord(buildWord(functDivu, rs, divisorReg(), 5'd0));
			4: issueWord(buildWord(functBds, divisorReg(), divisorReg(), 5'd0));
			5: issueWord(buildWord(functMthi, rs, 5'd0, 5'd0));
			6: issueWord(buildWord(functMtlo, rs, 5'd0, 5'd0));
			7: issueWord(buildWord(functMfhi, 5'd0, 5'd0, rd));
			default: issueWord(buildWord(functMflo, 5'd0, 5'd0, rd));
		endcase
	endtask

	initial begin
		seed = 32'hde86;
		reset = 1'b1;
		instr = '0;
		instrValid = 1'b0;
		flush = 1'b0;
		loadEn = 1'b0;
		loadAddr = '0;
		loadData = '0;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		preloadRegs();

		moveSequence(functMult);
		moveSequence(functMultu);
		moveSequence(functDiv);
		moveSequence(functDivu);
		moveSequence(functBds);
		repeat (80) issueRandom();

		// Flush in the middle of a divide
		issueWord(buildWord(functDivu, 5'd3, 5'd4, 5'd0));
		waitBusy(1'b1);
		flush <= 1'b1;
		@(posedge clk);
		flush <= 1'b0;
		issueWord(buildWord(functMfhi, 5'd0, 5'd0, 5'd15));
		issueWord(buildWord(functMflo, 5'd0, 5'd0, 5'd16));
		waitBusy(1'b0);
		repeat (4) @(posedge clk);

		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0 && checkCount > 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== tb.f ====
source/mduPkg.sv
source/instrDecode.sv
source/regFile.sv
source/mulDivUnit.sv
source/resultWriteback.sv
source/mduTop.sv
testbench/mduChecker.sv
testbench/tbTop.sv

// ==== Makefile ====
# Verilator build and run of the MDU testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= tbTop
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Simulation completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
